// ==== files.f ====
src/lsu_pkg.sv
src/mem_bus_if.sv
src/pipe_register.sv
src/index_buffer.sv
src/lsu_unit.sv
src/data_mem.sv
src/lsu_top.sv
test/tb_lsu.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
(verilator --binary --assert -Wno-fatal --top-module tb_lsu -f files.f \
    -Mdir obj_dir -o tb_lsu && ./obj_dir/tb_lsu) > sim.log 2>&1 || echo "run returned an error" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0

// ==== test/tb_lsu.sv ====
module tb_lsu;

    localparam int num_ops   = 64;
    localparam int max_cycle = 40 * num_ops + 200;

    logic                                  clk;
    logic                                  reset;
    logic                                  req_valid;
    logic                                  req_rw;
    lsu_pkg::mem_op_e                      req_op;
    logic [lsu_pkg::nw_bits-1:0]           req_wid;
    logic [lsu_pkg::num_threads-1:0]       req_tmask;
    logic [31:0]                           req_pc;
    logic [lsu_pkg::nr_bits-1:0]           req_rd;
    logic                                  req_wb;
    logic [lsu_pkg::num_threads-1:0][31:0] req_base_addr;
    logic [31:0]                           req_offset;
    logic [lsu_pkg::num_threads-1:0][31:0] req_store_data;
    logic                                  req_ready;
    logic                                  ld_valid;
    logic [lsu_pkg::nw_bits-1:0]           ld_wid;
    logic [lsu_pkg::num_threads-1:0]       ld_tmask;
    logic [31:0]                           ld_pc;
    logic [lsu_pkg::nr_bits-1:0]           ld_rd;
    logic                                  ld_wb;
    logic [lsu_pkg::num_threads-1:0][31:0] ld_data;
    logic                                  ld_eop;
    logic                                  ld_ready;
    logic                                  st_valid;
    logic [lsu_pkg::nw_bits-1:0]           st_wid;
    logic [lsu_pkg::num_threads-1:0]       st_tmask;
    logic [31:0]                           st_pc;
    logic                                  st_ready;

    lsu_top dut0 (.*);

    logic [31:0] lfsr = 32'h1dc0_fc6c;
    logic [7:0]  model [256];
    int          cycles = 0;
    int          loads_issued = 0;
    int          loads_done = 0;
    logic        req_taken;
    logic        bp_on = 1'b0;
    logic [31:0] pc_next = 32'h100;

    // expected load results with the oldest at head
    logic [31:0]      q_pc   [64];
    logic [1:0]       q_wid  [64];
    logic [4:0]       q_rd   [64];
    logic             q_wb   [64];
    logic [3:0]       q_rem  [64];
    logic [3:0][31:0] q_data [64];
    logic [5:0]       head;
    logic [5:0]       tail;

    // store in flight
    logic [2:0]       st_op_s;
    logic [3:0][7:0]  st_addr_s;
    logic [3:0][31:0] st_data_s;
    logic [31:0]      last_pc;
    logic [3:0]       last_mask;
    logic [1:0]       last_wid;

    logic        ld_fire;
    logic        st_fire;
    logic        data_bad;
    logic [31:0] bad_exp;
    logic [31:0] bad_act;

    always #20 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic is_store(input logic [2:0] op);
        return op == lsu_pkg::sb || op == lsu_pkg::sh || op == lsu_pkg::sw;
    endfunction

    // 1, 2 or 4 bytes
    function automatic int op_bytes(input logic [2:0] op);
        case (op)
            lsu_pkg::lb, lsu_pkg::lbu, lsu_pkg::sb: return 1;
            lsu_pkg::lh, lsu_pkg::lhu, lsu_pkg::sh: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic [31:0] load_value(input logic [2:0] op, input logic [7:0] a);
        logic [31:0] v;
        v = {model[a + 8'd3], model[a + 8'd2], model[a + 8'd1], model[a]};
        case (op)
            lsu_pkg::lb:  return {{24{v[7]}}, v[7:0]};
            lsu_pkg::lbu: return {24'h0, v[7:0]};
            lsu_pkg::lh:  return {{16{v[15]}}, v[15:0]};
            lsu_pkg::lhu: return {16'h0, v[15:0]};
            default:      return v;
        endcase
    endfunction

    task automatic fail_run();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    assign ld_fire = ld_valid && ld_ready;
    assign st_fire = st_valid && st_ready;

    always_comb begin
        data_bad = 1'b0;
        bad_exp  = '0;
        bad_act  = '0;
        for (int i = 0; i < 4; i++) begin
            if (ld_tmask[i] && !data_bad && ld_data[i] !== q_data[head][i]) begin
                data_bad = 1'b1;
                bad_exp  = q_data[head][i];
                bad_act  = ld_data[i];
            end
        end
    end

    // store commits go first, then the request taken at this edge
    always @(posedge clk) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (st_fire) begin
                for (int i = 3; i >= 0; i--) begin
                    if (st_tmask[i]) begin
                        for (int b = 0; b < op_bytes(st_op_s); b++) begin
                            model[st_addr_s[i] + 8'(b)] = st_data_s[i][b*8 +: 8];
                        end
                    end
                end
            end
            if (req_valid && req_ready) begin
                req_taken = 1'b1;
                last_pc   <= req_pc;
                last_mask <= req_tmask;
                last_wid  <= req_wid;
                if (is_store(req_op)) begin
                    st_op_s = req_op;
                    for (int i = 0; i < 4; i++) begin
                        st_addr_s[i] = 8'(req_base_addr[i] + req_offset);
                        st_data_s[i] = req_store_data[i];
                    end
                end else begin
                    q_pc[tail]  <= req_pc;
                    q_wid[tail] <= req_wid;
                    q_rd[tail]  <= req_rd;
                    q_wb[tail]  <= req_wb;
                    q_rem[tail] <= req_tmask;
                    for (int i = 0; i < 4; i++) begin
                        q_data[tail][i] <= load_value(req_op, 8'(req_base_addr[i] + req_offset));
                    end
                    tail <= tail + 6'd1;
                    loads_issued++;
                end
            end
            if (ld_fire) begin
                q_rem[head] <= q_rem[head] & ~ld_tmask;
                if ((q_rem[head] & ~ld_tmask) == '0) begin
                    head <= head + 6'd1;
                end
                if (ld_eop) begin
                    loads_done++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycle) begin
            $display("timeout after %0d cycles with loads still pending", cycles);
            fail_run();
        end
    end

    assert property (@(posedge clk) reset |=> !ld_valid && !st_valid)
        else begin
            $display("Error ld_valid/st_valid expected 0 actual %h/%h", ld_valid, st_valid);
            fail_run();
        end
    assert property (@(posedge clk) disable iff (reset) st_fire |-> st_pc == last_pc)
        else begin
            $display("Error st_pc expected %h actual %h", last_pc, st_pc);
            fail_run();
        end
    assert property (@(posedge clk) disable iff (reset) st_fire |-> st_tmask == last_mask)
        else begin
            $display("Error st_tmask expected %h actual %h", last_mask, st_tmask);
            fail_run();
        end
    assert property (@(posedge clk) disable iff (reset) st_fire |-> st_wid == last_wid)
        else begin
            $display("Error st_wid expected %h actual %h", last_wid, st_wid);
            fail_run();
        end
    assert property (@(posedge clk) disable iff (reset) ld_fire |-> head != tail)
        else begin
            $display("load result arrived with no load outstanding");
            fail_run();
        end
    assert property (@(posedge clk) disable iff (reset) ld_fire |-> ld_pc == q_pc[head])
        else begin
            $display("Error ld_pc expected %h actual %h", q_pc[head], ld_pc);
            fail_run();
        end
    assert property (@(posedge clk) disable iff (reset) ld_fire |-> ld_wid == q_wid[head])
        else begin
            $display("Error ld_wid expected %h actual %h", q_wid[head], ld_wid);
            fail_run();
        end
    assert property (@(posedge clk) disable iff (reset) ld_fire |-> ld_rd == q_rd[head])
        else begin
            $display("Error ld_rd expected %h actual %h", q_rd[head], ld_rd);
            fail_run();
        end
    assert property (@(posedge clk) disable iff (reset) ld_fire |-> ld_wb == q_wb[head])
        else begin
            $display("Error ld_wb expected %h actual %h", q_wb[head], ld_wb);
            fail_run();
        end
    assert property (@(posedge clk) disable iff (reset)
        ld_fire |-> (ld_tmask & ~q_rem[head]) == '0)
        else begin
            $display("Error ld_tmask expected within %h actual %h", q_rem[head], ld_tmask);
            fail_run();
        end
    assert property (@(posedge clk) disable iff (reset)
        ld_fire |-> ld_eop == ((q_rem[head] & ~ld_tmask) == '0))
        else begin
            $display("Error ld_eop expected %h actual %h",
                     (q_rem[head] & ~ld_tmask) == '0, ld_eop);
            fail_run();
        end
    assert property (@(posedge clk) disable iff (reset) ld_fire |-> !data_bad)
        else begin
            $display("Error ld_data expected %h actual %h", bad_exp, bad_act);
            fail_run();
        end
    assert property (@(posedge clk) disable iff (reset)
        ld_valid && !ld_ready |=> ld_valid
            && $stable({ld_wid, ld_pc, ld_rd, ld_wb, ld_tmask, ld_data, ld_eop}))
        else begin
            $display("Error ld held outputs expected %h actual %h",
                     $past({ld_valid, ld_wid, ld_pc, ld_rd, ld_wb, ld_tmask, ld_data, ld_eop}),
                     {ld_valid, ld_wid, ld_pc, ld_rd, ld_wb, ld_tmask, ld_data, ld_eop});
            fail_run();
        end

    task automatic send_req(input logic [2:0] op, input logic [3:0] mask,
                            input logic [3:0][31:0] bases, input logic [31:0] offs);
        req_valid      = 1'b1;
        req_op         = lsu_pkg::mem_op_e'(op);
        req_rw         = is_store(op);
        req_tmask      = mask;
        req_pc         = pc_next;
        req_wid        = rand_bits(2);
        req_rd         = rand_bits(5);
        req_wb         = !is_store(op);
        req_base_addr  = bases;
        req_offset     = offs;
        for (int i = 0; i < 4; i++) begin
            req_store_data[i] = rand_bits(32);
        end
        pc_next   = pc_next + 32'd4;
        req_taken = 1'b0;
        do begin
            @(negedge clk);
            ld_ready = bp_on ? (rand_bits(2) != 0) : 1'b1;
        end while (!req_taken);
    endtask

    // lanes land in separate quarters of memory
    function automatic logic [3:0][31:0] pick_bases();
        logic [3:0][31:0] b;
        for (int i = 0; i < 4; i++) begin
            b[i] = {24'h0, 2'(i), 4'(rand_bits(4)), 2'b00};
        end
        return b;
    endfunction

    initial begin
        logic [3:0][31:0] bases;
        logic [3:0]       mask;
        logic [2:0]       op;
        logic [31:0]      offs;
        clk = 1'b0;
        reset = 1'b1;
        req_valid = 1'b0;
        req_rw = 1'b0;
        req_op = lsu_pkg::lw;
        req_wid = '0;
        req_tmask = '0;
        req_pc = '0;
        req_rd = '0;
        req_wb = 1'b0;
        req_base_addr = '0;
        req_offset = '0;
        req_store_data = '0;
        ld_ready = 1'b1;
        st_ready = 1'b1;
        for (int a = 0; a < 256; a++) begin
            model[a] = 8'h00;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // word stores read back at the same addresses
        for (int k = 0; k < 8; k++) begin
            bases = pick_bases();
            mask  = 4'(rand_bits(4));
            if (mask == '0) mask = 4'b1111;
            send_req(lsu_pkg::sw, mask, bases, 32'd0);
            send_req(lsu_pkg::lw, mask, bases, 32'd0);
        end

        // mixed ops with random ld_ready stalls
        bp_on = 1'b1;
        for (int k = 0; k < 48; k++) begin
            bases = pick_bases();
            op    = 3'(rand_bits(3));
            mask  = 4'(rand_bits(4));
            if (mask == '0) mask = 4'(1 << rand_bits(2));
            offs  = 32'(rand_bits(2));
            if (op_bytes(op) == 2) offs[0] = 1'b0;
            if (op_bytes(op) == 4) offs = '0;
            send_req(op, mask, bases, offs);
        end

        req_valid = 1'b0;
        bp_on     = 1'b0;
        ld_ready  = 1'b1;
        while (head != tail) @(negedge clk);
        repeat (4) @(negedge clk);
        assert (loads_done == loads_issued)
            else begin
                $display("Error loads_done expected %h actual %h", loads_issued, loads_done);
                fail_run();
            end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== src/lsu_top.sv ====
module lsu_top (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  req_valid,
    input  logic                                  req_rw,
    input  lsu_pkg::mem_op_e                      req_op,
    input  logic [lsu_pkg::nw_bits-1:0]           req_wid,
    input  logic [lsu_pkg::num_threads-1:0]       req_tmask,
    input  logic [31:0]                           req_pc,
    input  logic [lsu_pkg::nr_bits-1:0]           req_rd,
    input  logic                                  req_wb,
    input  logic [lsu_pkg::num_threads-1:0][31:0] req_base_addr,
    input  logic [31:0]                           req_offset,
    input  logic [lsu_pkg::num_threads-1:0][31:0] req_store_data,
    output logic                                  req_ready,
    output logic                                  ld_valid,
    output logic [lsu_pkg::nw_bits-1:0]           ld_wid,
    output logic [lsu_pkg::num_threads-1:0]       ld_tmask,
    output logic [31:0]                           ld_pc,
    output logic [lsu_pkg::nr_bits-1:0]           ld_rd,
    output logic                                  ld_wb,
    output logic [lsu_pkg::num_threads-1:0][31:0] ld_data,
    output logic                                  ld_eop,
    input  logic                                  ld_ready,
    output logic                                  st_valid,
    output logic [lsu_pkg::nw_bits-1:0]           st_wid,
    output logic [lsu_pkg::num_threads-1:0]       st_tmask,
    output logic [31:0]                           st_pc,
    input  logic                                  st_ready
);

    mem_req_if        mem_req_bus ();
    mem_rsp_if        mem_rsp_bus ();
    lsu_pkg::commit_t ld;

    lsu_unit lsu0 (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req_rw         (req_rw),
        .req_op         (req_op),
        .req_wid        (req_wid),
        .req_tmask      (req_tmask),
        .req_pc         (req_pc),
        .req_rd         (req_rd),
        .req_wb         (req_wb),
        .req_base_addr  (req_base_addr),
        .req_offset     (req_offset),
        .req_store_data (req_store_data),
        .req_ready      (req_ready),
        .mem_req        (mem_req_bus.master),
        .mem_rsp        (mem_rsp_bus.slave),
        .ld             (ld),
        .ld_ready       (ld_ready),
        .st_valid       (st_valid),
        .st_wid         (st_wid),
        .st_tmask       (st_tmask),
        .st_pc          (st_pc),
        .st_ready       (st_ready)
    );

    data_mem mem0 (
        .clk     (clk),
        .reset   (reset),
        .mem_req (mem_req_bus.slave),
        .mem_rsp (mem_rsp_bus.master)
    );

    assign ld_valid = ld.valid;
    assign ld_wid   = ld.wid;
    assign ld_tmask = ld.tmask;
    assign ld_pc    = ld.pc;
    assign ld_rd    = ld.rd;
    assign ld_wb    = ld.wb;
    assign ld_data  = ld.data;
    assign ld_eop   = ld.eop;

endmodule

// ==== src/data_mem.sv ====
module data_mem (
    input logic       clk,
    input logic       reset,
    mem_req_if.slave  mem_req,
    mem_rsp_if.master mem_rsp
);

    logic [31:0] mem [lsu_pkg::mem_words];
    logic [lsu_pkg::num_threads-1:0] grant;
    logic [lsu_pkg::num_threads-1:0] load_grant;
    logic rsp_held;

    assign rsp_held = (|mem_rsp.valid) && !mem_rsp.ready;

    // lowest valid lanes first up to the port count
    always_comb begin
        int unsigned granted;
        grant   = '0;
        granted = 0;
        for (int i = 0; i < lsu_pkg::num_threads; i++) begin
            if (mem_req.valid[i] && (granted < lsu_pkg::mem_ports) && !rsp_held) begin
                grant[i] = 1'b1;
                granted++;
            end
        end
    end

    assign mem_req.ready = grant;
    assign load_grant    = grant & ~mem_req.rw;

    // lane 0 written last so it wins on a shared word
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < lsu_pkg::mem_words; w++) begin
                mem[w] <= '0;
            end
        end else begin
            for (int i = lsu_pkg::num_threads - 1; i >= 0; i--) begin
                if (grant[i] && mem_req.rw[i]) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_req.byteen[i][b]) begin
                            mem[mem_req.addr[i][lsu_pkg::mem_addr_bits-1:0]][b*8 +: 8]
                                <= mem_req.data[i][b*8 +: 8];
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_rsp.valid <= '0;
        end else if (|load_grant) begin
            mem_rsp.valid <= load_grant;
        end else if (mem_rsp.ready) begin
            mem_rsp.valid <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (|load_grant) begin
            mem_rsp.tag <= mem_req.tag[0];
            // only the enabled bytes come back
            for (int i = 0; i < lsu_pkg::num_threads; i++) begin
                for (int b = 0; b < 4; b++) begin
                    mem_rsp.data[i][b*8 +: 8] <= mem_req.byteen[i][b]
                        ? mem[mem_req.addr[i][lsu_pkg::mem_addr_bits-1:0]][b*8 +: 8]
                        : 8'h00;
                end
            end
        end
    end

endmodule

// ==== src/lsu_unit.sv ====
module lsu_unit (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  req_valid,
    input  logic                                  req_rw,
    input  lsu_pkg::mem_op_e                      req_op,
    input  logic [lsu_pkg::nw_bits-1:0]           req_wid,
    input  logic [lsu_pkg::num_threads-1:0]       req_tmask,
    input  logic [31:0]                           req_pc,
    input  logic [lsu_pkg::nr_bits-1:0]           req_rd,
    input  logic                                  req_wb,
    input  logic [lsu_pkg::num_threads-1:0][31:0] req_base_addr,
    input  logic [31:0]                           req_offset,
    input  logic [lsu_pkg::num_threads-1:0][31:0] req_store_data,
    output logic                                  req_ready,
    mem_req_if.master                             mem_req,
    mem_rsp_if.slave                              mem_rsp,
    output lsu_pkg::commit_t                      ld,
    input  logic                                  ld_ready,
    output logic                                  st_valid,
    output logic [lsu_pkg::nw_bits-1:0]           st_wid,
    output logic [lsu_pkg::num_threads-1:0]       st_tmask,
    output logic [31:0]                           st_pc,
    input  logic                                  st_ready
);

    lsu_pkg::lsu_req_t stage_in;
    lsu_pkg::lsu_req_t stage;
    lsu_pkg::meta_t    meta_in;
    lsu_pkg::meta_t    meta_out;
    lsu_pkg::commit_t  commit_in;

    logic [1:0] op_size;
    logic [1:0] op_sext;
    logic [3:0] wmask;

    logic ready_dep;
    logic ready_in;
    logic stall_in;
    logic sent_all;
    logic ld_stall;
    logic [lsu_pkg::num_threads-1:0] sent_mask;
    logic [lsu_pkg::num_threads-1:0] req_fire;

    logic [lsu_pkg::tag_bits-1:0] mbuf_waddr;
    logic [lsu_pkg::tag_bits-1:0] mbuf_raddr;
    logic [lsu_pkg::tag_bits-1:0] tag_hold;
    logic [lsu_pkg::tag_bits-1:0] req_tag;
    logic mbuf_full;
    logic mbuf_push;
    logic mbuf_pop;
    logic rsp_fire;
    logic [lsu_pkg::num_threads-1:0] rem_mask [lsu_pkg::lsuq_size];
    logic [lsu_pkg::num_threads-1:0] rem_mask_n;

    // op decode
    always_comb begin
        case (req_op)
            lsu_pkg::lb, lsu_pkg::lbu, lsu_pkg::sb: op_size = 2'd0;
            lsu_pkg::lh, lsu_pkg::lhu, lsu_pkg::sh: op_size = 2'd1;
            default:                                op_size = 2'd2;
        endcase
        case (req_op)
            lsu_pkg::lb: op_sext = 2'd1;
            lsu_pkg::lh: op_sext = 2'd2;
            default:     op_sext = 2'd0;
        endcase
        case (op_size)
            2'd0:    wmask = 4'b0001;
            2'd1:    wmask = 4'b0011;
            default: wmask = 4'b1111;
        endcase
    end

    // address generation
    always_comb begin
        stage_in.valid = req_valid;
        stage_in.wid   = req_wid;
        stage_in.tmask = req_tmask;
        stage_in.pc    = req_pc;
        stage_in.rw    = req_rw;
        stage_in.rd    = req_rd;
        stage_in.wb    = req_wb;
        stage_in.sext  = op_sext;
        for (int i = 0; i < lsu_pkg::num_threads; i++) begin
            stage_in.full_addr[i] = req_base_addr[i] + req_offset;
            stage_in.addr[i]      = stage_in.full_addr[i][31:2];
            stage_in.offset[i]    = stage_in.full_addr[i][1:0];
            stage_in.byteen[i]    = wmask << stage_in.full_addr[i][1:0];
            stage_in.data[i]      = req_store_data[i] << {stage_in.full_addr[i][1:0], 3'b000};
        end
    end

    pipe_register #(
        .payload_t (lsu_pkg::lsu_req_t)
    ) req_reg (
        .clk      (clk),
        .reset    (reset),
        .enable   (!stall_in),
        .data_in  (stage_in),
        .data_out (stage)
    );

    // a load keeps submitting once its slot is held, even if the buffer fills
    assign ready_dep = stage.rw ? st_ready : (!mbuf_full || (sent_mask != '0));
    assign req_fire  = mem_req.valid & mem_req.ready;
    assign sent_all  = ((req_fire | sent_mask) & stage.tmask) == stage.tmask;
    assign ready_in  = ready_dep && sent_all;
    assign stall_in  = stage.valid && !ready_in;
    assign req_ready = !stall_in;

    always_ff @(posedge clk) begin
        if (reset) begin
            sent_mask <= '0;
        end else if (sent_all) begin
            sent_mask <= '0;
        end else begin
            sent_mask <= sent_mask | req_fire;
        end
    end

    assign mbuf_push = (|req_fire) && (sent_mask == '0) && !stage.rw;
    assign req_tag   = (sent_mask == '0) ? mbuf_waddr : tag_hold;

    // tag must survive a split submission
    always_ff @(posedge clk) begin
        if (mbuf_push) begin
            tag_hold <= mbuf_waddr;
        end
    end

    assign mem_req.valid  = {lsu_pkg::num_threads{stage.valid && ready_dep}}
                          & stage.tmask & ~sent_mask;
    assign mem_req.rw     = {lsu_pkg::num_threads{stage.rw}};
    assign mem_req.addr   = stage.addr;
    assign mem_req.byteen = stage.byteen;
    assign mem_req.data   = stage.data;
    assign mem_req.tag    = {lsu_pkg::num_threads{req_tag}};

    assign st_valid = stage.valid && stage.rw && sent_all;
    assign st_wid   = stage.wid;
    assign st_tmask = stage.tmask;
    assign st_pc    = stage.pc;

    assign meta_in.wid    = stage.wid;
    assign meta_in.pc     = stage.pc;
    assign meta_in.rd     = stage.rd;
    assign meta_in.wb     = stage.wb;
    assign meta_in.offset = stage.offset;
    assign meta_in.sext   = stage.sext;

    index_buffer req_meta (
        .clk          (clk),
        .reset        (reset),
        .acquire      (mbuf_push),
        .write_data   (meta_in),
        .write_addr   (mbuf_waddr),
        .read_addr    (mbuf_raddr),
        .read_data    (meta_out),
        .release_slot (mbuf_pop),
        .full         (mbuf_full)
    );

    assign mbuf_raddr = mem_rsp.tag;
    assign rsp_fire   = (|mem_rsp.valid) && mem_rsp.ready;
    assign rem_mask_n = rem_mask[mbuf_raddr] & ~mem_rsp.valid;
    assign mbuf_pop   = rsp_fire && (rem_mask_n == '0);

    // lanes still owed per slot
    always_ff @(posedge clk) begin
        if (mbuf_push) begin
            rem_mask[mbuf_waddr] <= stage.tmask;
        end
        if (rsp_fire) begin
            rem_mask[mbuf_raddr] <= rem_mask_n;
        end
    end

    // align and extend
    always_comb begin
        logic [31:0] shifted;
        commit_in.valid = |mem_rsp.valid;
        commit_in.wid   = meta_out.wid;
        commit_in.tmask = mem_rsp.valid;
        commit_in.pc    = meta_out.pc;
        commit_in.rd    = meta_out.rd;
        commit_in.wb    = meta_out.wb;
        commit_in.eop   = mbuf_pop;
        for (int i = 0; i < lsu_pkg::num_threads; i++) begin
            shifted = mem_rsp.data[i] >> {meta_out.offset[i], 3'b000};
            case (meta_out.sext)
                2'd1:    commit_in.data[i] = {{24{shifted[7]}}, shifted[7:0]};
                2'd2:    commit_in.data[i] = {{16{shifted[15]}}, shifted[15:0]};
                default: commit_in.data[i] = shifted;
            endcase
        end
    end

    assign ld_stall      = ld.valid && !ld_ready;
    assign mem_rsp.ready = !ld_stall;

    pipe_register #(
        .payload_t (lsu_pkg::commit_t)
    ) rsp_reg (
        .clk      (clk),
        .reset    (reset),
        .enable   (!ld_stall),
        .data_in  (commit_in),
        .data_out (ld)
    );

endmodule

// ==== src/index_buffer.sv ====
module index_buffer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         acquire,
    input  lsu_pkg::meta_t               write_data,
    output logic [lsu_pkg::tag_bits-1:0] write_addr,
    input  logic [lsu_pkg::tag_bits-1:0] read_addr,
    output lsu_pkg::meta_t               read_data,
    input  logic                         release_slot,
    output logic                         full
);

    logic [lsu_pkg::lsuq_size-1:0] busy;
    lsu_pkg::meta_t                meta_mem [lsu_pkg::lsuq_size];

    // lowest free slot
    always_comb begin
        write_addr = '0;
        for (int i = lsu_pkg::lsuq_size - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                write_addr = i[lsu_pkg::tag_bits-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (acquire) begin
                busy[write_addr] <= 1'b1;
            end
            if (release_slot) begin
                busy[read_addr] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acquire) begin
            meta_mem[write_addr] <= write_data;
        end
    end

    assign read_data = meta_mem[read_addr];
    assign full      = &busy;

endmodule

// ==== src/pipe_register.sv ====
module pipe_register #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     enable,
    input  payload_t data_in,
    output payload_t data_out
);

    always_ff @(posedge clk) begin
        if (reset) begin
            data_out <= '0;
        end else if (enable) begin
            data_out <= data_in;
        end
    end

endmodule

// ==== src/mem_bus_if.sv ====
interface mem_req_if;
    logic [lsu_pkg::num_threads-1:0]                    valid;
    logic [lsu_pkg::num_threads-1:0]                    rw;
    logic [lsu_pkg::num_threads-1:0][29:0]              addr;
    logic [lsu_pkg::num_threads-1:0][3:0]               byteen;
    logic [lsu_pkg::num_threads-1:0][31:0]              data;
    logic [lsu_pkg::num_threads-1:0][lsu_pkg::tag_bits-1:0] tag;
    logic [lsu_pkg::num_threads-1:0]                    ready;

    modport master (
        output valid,
        output rw,
        output addr,
        output byteen,
        output data,
        output tag,
        input  ready
    );

    modport slave (
        input  valid,
        input  rw,
        input  addr,
        input  byteen,
        input  data,
        input  tag,
        output ready
    );
endinterface

interface mem_rsp_if;
    logic [lsu_pkg::num_threads-1:0]       valid;
    logic [lsu_pkg::num_threads-1:0][31:0] data;
    logic [lsu_pkg::tag_bits-1:0]          tag;
    logic                                  ready;

    modport master (
        output valid,
        output data,
        output tag,
        input  ready
    );

    modport slave (
        input  valid,
        input  data,
        input  tag,
        output ready
    );
endinterface

// ==== src/lsu_pkg.sv ====
package lsu_pkg;

    localparam int num_threads   = 4;
    localparam int nw_bits       = 2;
    localparam int nr_bits       = 5;
    localparam int lsuq_size     = 4;
    localparam int tag_bits      = 2;
    localparam int mem_words     = 64;
    localparam int mem_addr_bits = $clog2(mem_words);
    localparam int mem_ports     = 2;

    // load size in bits 1:0 and unsigned flag in bit 2
    // sb and sh sit on the two spare codes
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        sb  = 3'b011,
        lbu = 3'b100,
        lhu = 3'b101,
        sw  = 3'b110,
        sh  = 3'b111
    } mem_op_e;

    typedef struct packed {
        logic                               valid;
        logic [nw_bits-1:0]                 wid;
        logic [num_threads-1:0]             tmask;
        logic [31:0]                        pc;
        logic                               rw;
        logic [nr_bits-1:0]                 rd;
        logic                               wb;
        logic [num_threads-1:0][31:0]       full_addr;
        logic [num_threads-1:0][29:0]       addr;
        logic [num_threads-1:0][1:0]        offset;
        logic [num_threads-1:0][3:0]        byteen;
        logic [num_threads-1:0][31:0]       data;
        // 0 none, 1 byte, 2 half
        logic [1:0]                         sext;
    } lsu_req_t;

    typedef struct packed {
        logic                         valid;
        logic [nw_bits-1:0]           wid;
        logic [num_threads-1:0]       tmask;
        logic [31:0]                  pc;
        logic [nr_bits-1:0]           rd;
        logic                         wb;
        logic [num_threads-1:0][31:0] data;
        logic                         eop;
    } commit_t;

    typedef struct packed {
        logic [nw_bits-1:0]           wid;
        logic [31:0]                  pc;
        logic [nr_bits-1:0]           rd;
        logic                         wb;
        logic [num_threads-1:0][1:0]  offset;
        logic [1:0]                   sext;
    } meta_t;

endpackage
